//--- hw/cpuPkg.sv
// Shared word types, opcode and ALU encodings for the single-cycle core; referenced by scoped name
`default_nettype none

package cpuPkg;

   // Data and instruction word
   typedef logic [15:0] wordT;

   // Register index, eight registers
   typedef logic [2:0] regIdxT;

   // Major opcode in instr[15:11]
   typedef enum logic [4:0]
   {
      opHalt = 5'b00000,
      opNop  = 5'b00001,
      opJ    = 5'b00100,
      opAddi = 5'b01000,
      opBeqz = 5'b01100,
      opBnez = 5'b01101,
      opSt   = 5'b10000,
      opLd   = 5'b10001,
      opSlbi = 5'b10010,
      opLbi  = 5'b11000,
      opAlu  = 5'b11011
   } opcodeT;

   // Execute operation chosen by the decoder
   typedef enum logic [2:0]
   {
      aluAdd,
      aluSub,
      aluXor,
      aluAndNot,
      aluPassImm,
      aluShiftLoadImm
   } aluOpT;

   // Immediate formats
   typedef enum logic [1:0]
   {
      immS5,   // ADDI, LD, ST
      immS8,   // LBI, BEQZ, BNEZ
      immU8,   // SLBI
      immS11   // J
   } immSelT;

   // Stores at or above this address go to the output port
   parameter wordT ioBase = 16'hFF00;

endpackage

`default_nettype wire

//--- hw/instrFetch.sv
// Fetch stage holding the PC and instruction memory, loaded externally before a run
`timescale 1ns/1ns
`default_nettype none

module instrFetch #(
   parameter int imemAddrWidth = 8
) (
   input  wire                           clk,
   input  wire                           rst,
   input  wire                           start,
   input  wire                           pcEnable,
   input  wire                           takeTarget,
   input  cpuPkg::wordT                  target,
   input  wire                           loadEn,
   input  wire         [imemAddrWidth-1:0] loadAddr,
   input  cpuPkg::wordT                  loadData,
   output cpuPkg::wordT                  instr,
   output cpuPkg::wordT                  pcPlusOne
);

   localparam int imemDepth = 1 << imemAddrWidth;

   cpuPkg::wordT pc;
   cpuPkg::wordT imem [imemDepth];

   // Program image written one word per strobe
   always_ff @(posedge clk)
   begin
      if (loadEn)
      begin
         imem[loadAddr] <= loadData;
      end
   end

   // PC counts words, upper bits wrap past the memory depth
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         pc <= '0;
      end
      else if (start)
      begin
         pc <= '0;
      end
      else if (pcEnable)
      begin
         pc <= takeTarget ? target : pcPlusOne;
      end
   end

   assign pcPlusOne = pc + 16'd1;

   // Asynchronous read so the instruction is ready in its own cycle
   assign instr = imem[pc[imemAddrWidth-1:0]];

endmodule

`default_nettype wire

//--- hw/controlUnit.sv
// Decoder and run control: turns the opcode into datapath controls and holds busy and err
`timescale 1ns/1ns
`default_nettype none

module controlUnit (
   input  wire                   clk,
   input  wire                   rst,
   input  wire                   start,
   input  cpuPkg::wordT          instr,
   input  wire                   overflow,
   output logic                  busy,
   output logic                  err,
   output logic                  pcEnable,
   output logic                  regWrite,
   output logic                  memWrite,
   output logic                  memRead,
   output logic                  aluSrc,
   output cpuPkg::aluOpT         aluOp,
   output cpuPkg::immSelT        immSel,
   output logic                  isBranch,
   output logic                  branchOnZero,
   output logic                  isJump,
   output cpuPkg::regIdxT        readIdx1,
   output cpuPkg::regIdxT        readIdx2,
   output cpuPkg::regIdxT        writeIdx
);

   cpuPkg::opcodeT opcode;
   logic           decRegWrite;
   logic           decMemWrite;
   logic           isHalt;
   logic           illegal;
   logic           arithOp;

   assign opcode = cpuPkg::opcodeT'(instr[15:11]);

   // rs and rt sit at fixed positions; ST reads its data register through port 2
   assign readIdx1 = instr[10:8];
   assign readIdx2 = instr[7:5];

   always_comb
   begin
      decRegWrite  = 1'b0;
      decMemWrite  = 1'b0;
      memRead      = 1'b0;
      aluSrc       = 1'b1;
      aluOp        = cpuPkg::aluAdd;
      immSel       = cpuPkg::immS5;
      isBranch     = 1'b0;
      branchOnZero = 1'b0;
      isJump       = 1'b0;
      isHalt       = 1'b0;
      illegal      = 1'b0;
      arithOp      = 1'b0;
      writeIdx     = instr[7:5];
      case (opcode)
         cpuPkg::opHalt: isHalt = 1'b1;
         cpuPkg::opNop: ;
         cpuPkg::opJ:
         begin
            isJump = 1'b1;
            immSel = cpuPkg::immS11;
         end
         cpuPkg::opAddi:
         begin
            decRegWrite = 1'b1;
            arithOp     = 1'b1;
         end
         cpuPkg::opBeqz, cpuPkg::opBnez:
         begin
            isBranch     = 1'b1;
            branchOnZero = (opcode == cpuPkg::opBeqz);
            immSel       = cpuPkg::immS8;
         end
         cpuPkg::opSt: decMemWrite = 1'b1;
         cpuPkg::opLd:
         begin
            decRegWrite = 1'b1;
            memRead     = 1'b1;
         end
         cpuPkg::opSlbi, cpuPkg::opLbi:
         begin
            decRegWrite = 1'b1;
            writeIdx    = instr[10:8];
            immSel      = (opcode == cpuPkg::opLbi) ? cpuPkg::immS8 : cpuPkg::immU8;
            aluOp       = (opcode == cpuPkg::opLbi) ? cpuPkg::aluPassImm
                                                    : cpuPkg::aluShiftLoadImm;
         end
         cpuPkg::opAlu:
         begin
            decRegWrite = 1'b1;
            aluSrc      = 1'b0;
            writeIdx    = instr[4:2];
            // Function field: add, sub, xor, andNot
            case (instr[1:0])
               2'b00: aluOp = cpuPkg::aluAdd;
               2'b01: aluOp = cpuPkg::aluSub;
               2'b10: aluOp = cpuPkg::aluXor;
               default: aluOp = cpuPkg::aluAndNot;
            endcase
            arithOp = ~instr[1];
         end
         default: illegal = 1'b1;
      endcase
   end

   // Idle core changes nothing; HALT and illegal decode already write nothing
   assign pcEnable = busy & ~isHalt & ~illegal;
   assign regWrite = busy & decRegWrite;
   assign memWrite = busy & decMemWrite;

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         busy <= 1'b0;
         err  <= 1'b0;
      end
      else if (start && !busy)
      begin
         busy <= 1'b1;
         err  <= 1'b0;
      end
      else if (busy)
      begin
         if (isHalt || illegal)
         begin
            busy <= 1'b0;
         end
         // Sticky until the next start; overflow alone keeps the core running
         if (illegal || (arithOp && overflow))
         begin
            err <= 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

//--- hw/registerFile.sv
// Eight-entry register file with two combinational reads and one clocked write
`timescale 1ns/1ns
`default_nettype none

module registerFile (
   input  wire              clk,
   input  wire              rst,
   input  wire              regWrite,
   input  cpuPkg::regIdxT   readIdx1,
   input  cpuPkg::regIdxT   readIdx2,
   input  cpuPkg::regIdxT   writeIdx,
   input  cpuPkg::wordT     writeData,
   output cpuPkg::wordT     readData1,
   output cpuPkg::wordT     readData2
);

   cpuPkg::wordT regs [8];

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         for (int i = 0; i < 8; i++)
         begin
            regs[i] <= '0;
         end
      end
      else if (regWrite)
      begin
         regs[writeIdx] <= writeData;
      end
   end

   // No bypass, a write shows up on the next cycle's read
   assign readData1 = regs[readIdx1];
   assign readData2 = regs[readIdx2];

endmodule

`default_nettype wire

//--- hw/executeUnit.sv
// Execute stage: immediate extension, ALU with signed overflow, and branch or jump target
`timescale 1ns/1ns
`default_nettype none

module executeUnit (
   input  cpuPkg::wordT     instr,
   input  cpuPkg::wordT     readData1,
   input  cpuPkg::wordT     readData2,
   input  cpuPkg::wordT     pcPlusOne,
   input  wire              aluSrc,
   input  cpuPkg::aluOpT    aluOp,
   input  cpuPkg::immSelT   immSel,
   input  wire              isBranch,
   input  wire              branchOnZero,
   input  wire              isJump,
   output cpuPkg::wordT     aluResult,
   output logic             overflow,
   output logic             takeTarget,
   output cpuPkg::wordT     target
);

   cpuPkg::wordT imm;
   cpuPkg::wordT opB;
   cpuPkg::wordT sum;
   cpuPkg::wordT diff;
   logic         isZero;

   always_comb
   begin
      case (immSel)
         cpuPkg::immS5:  imm = {{11{instr[4]}}, instr[4:0]};
         cpuPkg::immS8:  imm = {{8{instr[7]}}, instr[7:0]};
         cpuPkg::immU8:  imm = {8'h00, instr[7:0]};
         default:        imm = {{5{instr[10]}}, instr[10:0]};
      endcase
   end

   assign opB  = aluSrc ? imm : readData2;
   assign sum  = readData1 + opB;
   // SUB computes rs minus rt
   assign diff = readData1 - opB;

   always_comb
   begin
      overflow = 1'b0;
      case (aluOp)
         cpuPkg::aluAdd:
         begin
            aluResult = sum;
            overflow  = (readData1[15] == opB[15]) && (sum[15] != readData1[15]);
         end
         cpuPkg::aluSub:
         begin
            aluResult = diff;
            overflow  = (readData1[15] != opB[15]) && (diff[15] != readData1[15]);
         end
         cpuPkg::aluXor:     aluResult = readData1 ^ opB;
         cpuPkg::aluAndNot:  aluResult = readData1 & ~opB;
         cpuPkg::aluPassImm: aluResult = imm;
         // SLBI: (rs << 8) | imm8
         default:            aluResult = {readData1[7:0], imm[7:0]};
      endcase
   end

   // Branch register is rs on read port 1
   assign isZero = (readData1 == '0);

   assign target     = pcPlusOne + imm;
   assign takeTarget = isJump | (isBranch & (isZero == branchOnZero));

endmodule

`default_nettype wire

//--- hw/memoryAccess.sv
// Memory stage: data RAM, memory-mapped output port and register write-back select
`timescale 1ns/1ns
`default_nettype none

module memoryAccess #(
   parameter int dmemAddrWidth = 8
) (
   input  wire            clk,
   input  wire            rst,
   input  wire            memWrite,
   input  wire            memRead,
   input  cpuPkg::wordT   aluResult,
   input  cpuPkg::wordT   storeData,
   output cpuPkg::wordT   writeData,
   output logic           ioValid,
   output cpuPkg::wordT   ioData
);

   localparam int dmemDepth = 1 << dmemAddrWidth;

   cpuPkg::wordT             ram [dmemDepth];
   logic [dmemAddrWidth-1:0] ramAddr;
   logic                     isIo;

   assign ramAddr = aluResult[dmemAddrWidth-1:0];
   assign isIo    = (aluResult >= cpuPkg::ioBase);

   // I/O stores never reach the RAM even though low bits alias
   always_ff @(posedge clk)
   begin
      if (memWrite && !isIo)
      begin
         ram[ramAddr] <= storeData;
      end
   end

   // Output strobe is high for the cycle after the store retires
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         ioValid <= 1'b0;
      end
      else
      begin
         ioValid <= memWrite & isIo;
      end
   end

   always_ff @(posedge clk)
   begin
      if (memWrite && isIo)
      begin
         ioData <= storeData;
      end
   end

   assign writeData = memRead ? ram[ramAddr] : aluResult;

endmodule

`default_nettype wire

//--- hw/cpuTop.sv
// Top level of the 16-bit single-cycle core; connects fetch, control, registers, execute, memory
`timescale 1ns/1ns
`default_nettype none

module cpuTop #(
   parameter int imemAddrWidth = 8,
   parameter int dmemAddrWidth = 8
) (
   input  wire                           clk,
   input  wire                           rst,
   input  wire                           loadEn,
   input  wire         [imemAddrWidth-1:0] loadAddr,
   input  cpuPkg::wordT                  loadData,
   input  wire                           start,
   output logic                          busy,
   output logic                          err,
   output logic                          ioValid,
   output cpuPkg::wordT                  ioData
);

   cpuPkg::wordT   instr;
   cpuPkg::wordT   pcPlusOne;
   cpuPkg::wordT   readData1;
   cpuPkg::wordT   readData2;
   cpuPkg::wordT   aluResult;
   cpuPkg::wordT   target;
   cpuPkg::wordT   writeData;
   cpuPkg::aluOpT  aluOp;
   cpuPkg::immSelT immSel;
   cpuPkg::regIdxT readIdx1;
   cpuPkg::regIdxT readIdx2;
   cpuPkg::regIdxT writeIdx;
   logic           pcEnable;
   logic           regWrite;
   logic           memWrite;
   logic           memRead;
   logic           aluSrc;
   logic           isBranch;
   logic           branchOnZero;
   logic           isJump;
   logic           overflow;
   logic           takeTarget;

   instrFetch #(.imemAddrWidth(imemAddrWidth)) i_instrFetch (
      .clk(clk), .rst(rst), .start(start), .pcEnable(pcEnable),
      .takeTarget(takeTarget), .target(target),
      .loadEn(loadEn), .loadAddr(loadAddr), .loadData(loadData),
      .instr(instr), .pcPlusOne(pcPlusOne)
   );

   controlUnit i_controlUnit (
      .clk(clk), .rst(rst), .start(start), .instr(instr), .overflow(overflow),
      .busy(busy), .err(err), .pcEnable(pcEnable), .regWrite(regWrite),
      .memWrite(memWrite), .memRead(memRead), .aluSrc(aluSrc), .aluOp(aluOp),
      .immSel(immSel), .isBranch(isBranch), .branchOnZero(branchOnZero),
      .isJump(isJump), .readIdx1(readIdx1), .readIdx2(readIdx2), .writeIdx(writeIdx)
   );

   registerFile i_registerFile (
      .clk(clk), .rst(rst), .regWrite(regWrite),
      .readIdx1(readIdx1), .readIdx2(readIdx2), .writeIdx(writeIdx),
      .writeData(writeData), .readData1(readData1), .readData2(readData2)
   );

   executeUnit i_executeUnit (
      .instr(instr), .readData1(readData1), .readData2(readData2),
      .pcPlusOne(pcPlusOne), .aluSrc(aluSrc), .aluOp(aluOp), .immSel(immSel),
      .isBranch(isBranch), .branchOnZero(branchOnZero), .isJump(isJump),
      .aluResult(aluResult), .overflow(overflow),
      .takeTarget(takeTarget), .target(target)
   );

   // Store data is the rd register read on port 2
   memoryAccess #(.dmemAddrWidth(dmemAddrWidth)) i_memoryAccess (
      .clk(clk), .rst(rst), .memWrite(memWrite), .memRead(memRead),
      .aluResult(aluResult), .storeData(readData2),
      .writeData(writeData), .ioValid(ioValid), .ioData(ioData)
   );

endmodule

`default_nettype wire

//--- verification/cpuTop_properties.sv
// Concurrent checks on run control and the output strobe, attached to cpuTop through bind
`timescale 1ns/1ns
`default_nettype none

module cpuTopProperties (
   input wire clk,
   input wire rst,
   input wire start,
   input wire busy,
   input wire err,
   input wire ioValid
);

   // Quiet core right after reset
   resetIdle: assert property (@(posedge clk) rst |=> (!busy && !ioValid))
      else $error("busy or ioValid high in the cycle after reset");

   // A port word only follows a running cycle
   ioFromRun: assert property (@(posedge clk) disable iff (rst) ioValid |-> $past(busy))
      else $error("ioValid without busy in the previous cycle");

   errSticky: assert property (@(posedge clk) disable iff (rst) (err && !start) |=> err)
      else $error("err cleared without rst or start");

   // Only start launches a run
   busyNeedsStart: assert property (@(posedge clk) disable iff (rst) (!busy && !start) |=> !busy)
      else $error("busy rose without start");

endmodule

`default_nettype wire

//--- verification/cpuTb.sv
// Directed testbench for cpuTop: assembles small programs, loads and runs them, checks the port
`timescale 1ns/1ns
`default_nettype none

module cpuTb;

   // Longest program with its loop is under 60 cycles; six tests with reloads fit well inside
   localparam int maxCycles = 3000;

   logic         clk;
   logic         rst;
   logic         loadEn;
   logic [7:0]   loadAddr;
   cpuPkg::wordT loadData;
   logic         start;
   logic         busy;
   logic         err;
   logic         ioValid;
   cpuPkg::wordT ioData;

   cpuPkg::wordT prog [$];
   cpuPkg::wordT expQ [$];
   cpuPkg::wordT outQ [$];
   string        curTest;
   int           testStartErrors;
   int           runCycles;
   int           errorCount = 0;
   int           checkCount = 0;
   int           testCount = 0;
   int           cycleCount = 0;

   cpuTop i_cpuTop (
      .clk(clk), .rst(rst), .loadEn(loadEn), .loadAddr(loadAddr), .loadData(loadData),
      .start(start), .busy(busy), .err(err), .ioValid(ioValid), .ioData(ioData)
   );

   bind cpuTop cpuTopProperties i_cpuTopProperties (
      .clk(clk), .rst(rst), .start(start), .busy(busy), .err(err), .ioValid(ioValid)
   );

   always #10 clk = ~clk;

   always @(posedge clk)
   begin
      cycleCount <= cycleCount + 1;
      if (cycleCount >= maxCycles)
      begin
         $display("Timeout: the run did not finish within %0d cycles", maxCycles);
         $display("SIMULATION FAILED");
         $finish;
      end
   end

   // Instruction encoders
   function automatic cpuPkg::wordT aluWord(input cpuPkg::regIdxT rd, input cpuPkg::regIdxT rs,
                                            input cpuPkg::regIdxT rt, input logic [1:0] fn);
      return {cpuPkg::opAlu, rs, rt, rd, fn};
   endfunction

   function automatic cpuPkg::wordT shortImmWord(input cpuPkg::opcodeT op,
                                                 input cpuPkg::regIdxT rd,
                                                 input cpuPkg::regIdxT rs, input logic [4:0] imm);
      return {op, rs, rd, imm};
   endfunction

   function automatic cpuPkg::wordT byteImmWord(input cpuPkg::opcodeT op,
                                                input cpuPkg::regIdxT rs, input logic [7:0] imm);
      return {op, rs, imm};
   endfunction

   function automatic cpuPkg::wordT jumpWord(input logic [10:0] disp);
      return {cpuPkg::opJ, disp};
   endfunction

   task automatic emit(input cpuPkg::wordT w);
      prog.push_back(w);
   endtask

   // LBI then SLBI builds any 16-bit constant
   task automatic loadConst(input cpuPkg::regIdxT r, input cpuPkg::wordT v);
      emit(byteImmWord(cpuPkg::opLbi, r, v[15:8]));
      emit(byteImmWord(cpuPkg::opSlbi, r, v[7:0]));
   endtask

   // r7 holds the output port address
   task automatic storeOut(input cpuPkg::regIdxT r);
      emit(shortImmWord(cpuPkg::opSt, r, 3'd7, 5'd0));
   endtask

   task automatic beginTest(input string name);
      curTest = name;
      testStartErrors = errorCount;
      prog.delete();
      expQ.delete();
   endtask

   task automatic endTest();
      testCount++;
      $display("Test %s finished with %0d errors", curTest, errorCount - testStartErrors);
   endtask

   task automatic checkWord(input cpuPkg::wordT expected, input cpuPkg::wordT actual);
      checkCount++;
      if (actual !== expected)
      begin
         errorCount++;
         $display("FAIL %s: expected %h, actual %h", curTest, expected, actual);
      end
   endtask

   task automatic checkFlag(input string flagName, input logic expected, input logic actual);
      checkCount++;
      if (actual !== expected)
      begin
         errorCount++;
         $display("FAIL %s (%s): expected %b, actual %b", curTest, flagName, expected, actual);
      end
   endtask

   task automatic checkCycles(input int expected, input int actual);
      checkCount++;
      if (actual != expected)
      begin
         errorCount++;
         $display("FAIL %s (run cycles): expected %0d, actual %0d", curTest, expected, actual);
      end
   endtask

   task automatic compareOutputs();
      int i;
      if (outQ.size() != expQ.size())
      begin
         errorCount++;
         $display("%s: the port gave %0d words where %0d were expected",
                  curTest, outQ.size(), expQ.size());
      end
      for (i = 0; i < outQ.size() && i < expQ.size(); i++)
      begin
         checkWord(expQ[i], outQ[i]);
      end
   endtask

   task automatic loadProgram();
      int i;
      for (i = 0; i < prog.size(); i++)
      begin
         @(posedge clk);
         loadEn   <= 1'b1;
         loadAddr <= 8'(i);
         loadData <= prog[i];
      end
      @(posedge clk);
      loadEn <= 1'b0;
   endtask

   // Pulse start, then gather port words and count busy cycles until busy drops
   task automatic runProgram();
      outQ.delete();
      runCycles = 0;
      @(posedge clk);
      start <= 1'b1;
      @(posedge clk);
      start <= 1'b0;
      do
      begin
         @(negedge clk);
         if (busy)
         begin
            runCycles++;
         end
         if (ioValid)
         begin
            outQ.push_back(ioData);
         end
      end
      while (busy);
   endtask

   // Countdown loop with BNEZ, then BEQZ, BNEZ and J around marker stores
   task automatic buildControl();
      int count;
      loadConst(3'd7, cpuPkg::ioBase);
      emit(byteImmWord(cpuPkg::opLbi, 3'd1, 8'd5));
      emit(byteImmWord(cpuPkg::opLbi, 3'd2, 8'h11));
      emit(byteImmWord(cpuPkg::opLbi, 3'd3, 8'h22));
      emit(byteImmWord(cpuPkg::opLbi, 3'd4, 8'h33));
      emit(byteImmWord(cpuPkg::opLbi, 3'd5, 8'h44));
      storeOut(3'd1);
      emit(shortImmWord(cpuPkg::opAddi, 3'd1, 3'd1, 5'h1F));
      emit(byteImmWord(cpuPkg::opBnez, 3'd1, 8'hFD));
      for (count = 5; count > 0; count--)
      begin
         expQ.push_back(cpuPkg::wordT'(count));
      end
      emit(byteImmWord(cpuPkg::opBeqz, 3'd1, 8'd1));
      storeOut(3'd2);
      storeOut(3'd3);
      expQ.push_back(16'h0022);
      emit(byteImmWord(cpuPkg::opBnez, 3'd1, 8'd1));
      storeOut(3'd4);
      expQ.push_back(16'h0033);
      emit(jumpWord(11'd1));
      storeOut(3'd2);
      storeOut(3'd5);
      expQ.push_back(16'h0044);
      emit(16'h0000);
   endtask

   task automatic testIdle();
      int i;
      logic sawOutput;
      beginTest("idle");
      sawOutput = 1'b0;
      @(negedge clk);
      checkFlag("busy", 1'b0, busy);
      checkFlag("err", 1'b0, err);
      checkFlag("ioValid", 1'b0, ioValid);
      loadConst(3'd7, cpuPkg::ioBase);
      storeOut(3'd7);
      emit(16'h0000);
      loadProgram();
      for (i = 0; i < 10; i++)
      begin
         @(negedge clk);
         sawOutput = sawOutput | ioValid | busy;
      end
      checkFlag("activity without start", 1'b0, sawOutput);
      endTest();
   endtask

   task automatic testArith();
      cpuPkg::wordT a;
      cpuPkg::wordT b;
      logic [4:0]   imm5;
      beginTest("arith");
      // Operands kept within +-0x2000 so no result overflows
      a = cpuPkg::wordT'($urandom & 32'h3FFF) - 16'h2000;
      b = cpuPkg::wordT'($urandom & 32'h3FFF) - 16'h2000;
      imm5 = 5'($urandom);
      loadConst(3'd7, cpuPkg::ioBase);
      loadConst(3'd1, a);
      loadConst(3'd2, b);
      emit(aluWord(3'd3, 3'd1, 3'd2, 2'b00));
      storeOut(3'd3);
      emit(aluWord(3'd3, 3'd1, 3'd2, 2'b01));
      storeOut(3'd3);
      emit(aluWord(3'd3, 3'd1, 3'd2, 2'b10));
      storeOut(3'd3);
      emit(aluWord(3'd3, 3'd1, 3'd2, 2'b11));
      storeOut(3'd3);
      emit(shortImmWord(cpuPkg::opAddi, 3'd4, 3'd1, imm5));
      storeOut(3'd4);
      emit(16'h0000);
      expQ.push_back(a + b);
      expQ.push_back(a - b);
      expQ.push_back(a ^ b);
      expQ.push_back(a & ~b);
      expQ.push_back(a + {{11{imm5[4]}}, imm5});
      loadProgram();
      runProgram();
      compareOutputs();
      // Straight-line code, one cycle per instruction up to and including HALT
      checkCycles(prog.size(), runCycles);
      checkFlag("err", 1'b0, err);
      endTest();
   endtask

   task automatic testMemory();
      cpuPkg::wordT x;
      cpuPkg::wordT y;
      cpuPkg::wordT z;
      beginTest("memory");
      x = cpuPkg::wordT'($urandom);
      y = cpuPkg::wordT'($urandom);
      z = cpuPkg::wordT'($urandom);
      loadConst(3'd7, cpuPkg::ioBase);
      loadConst(3'd1, x);
      loadConst(3'd2, y);
      loadConst(3'd5, z);
      loadConst(3'd4, 16'h0010);
      loadConst(3'd6, 16'hFF10);
      emit(shortImmWord(cpuPkg::opSt, 3'd1, 3'd4, 5'd0));
      emit(shortImmWord(cpuPkg::opSt, 3'd2, 3'd4, 5'd1));
      // Same low address bits as RAM word 0x10
      emit(shortImmWord(cpuPkg::opSt, 3'd5, 3'd6, 5'd0));
      emit(shortImmWord(cpuPkg::opLd, 3'd3, 3'd4, 5'd0));
      storeOut(3'd3);
      emit(shortImmWord(cpuPkg::opLd, 3'd3, 3'd4, 5'd1));
      storeOut(3'd3);
      emit(16'h0000);
      expQ.push_back(z);
      expQ.push_back(x);
      expQ.push_back(y);
      loadProgram();
      runProgram();
      compareOutputs();
      checkFlag("err", 1'b0, err);
      endTest();
   endtask

   task automatic testControl();
      beginTest("control");
      buildControl();
      loadProgram();
      runProgram();
      compareOutputs();
      checkFlag("err", 1'b0, err);
      endTest();
   endtask

   task automatic testErrors();
      int stopAt;
      beginTest("overflow");
      loadConst(3'd7, cpuPkg::ioBase);
      loadConst(3'd1, 16'h7FFF);
      loadConst(3'd2, 16'h0001);
      emit(aluWord(3'd3, 3'd1, 3'd2, 2'b00));
      storeOut(3'd3);
      storeOut(3'd2);
      emit(16'h0000);
      expQ.push_back(16'h7FFF + 16'h0001);
      expQ.push_back(16'h0001);
      loadProgram();
      runProgram();
      compareOutputs();
      checkFlag("err", 1'b1, err);
      endTest();
      beginTest("illegal");
      loadConst(3'd7, cpuPkg::ioBase);
      emit(byteImmWord(cpuPkg::opLbi, 3'd1, 8'h5A));
      storeOut(3'd1);
      // Run ends on the cycle of the illegal word
      stopAt = prog.size() + 1;
      emit(16'hF800);
      storeOut(3'd1);
      emit(16'h0000);
      expQ.push_back(16'h005A);
      loadProgram();
      runProgram();
      compareOutputs();
      checkFlag("err", 1'b1, err);
      checkCycles(stopAt, runCycles);
      endTest();
   endtask

   task automatic testRestart();
      beginTest("restart");
      checkFlag("err before restart", 1'b1, err);
      buildControl();
      loadProgram();
      runProgram();
      compareOutputs();
      checkFlag("err after first run", 1'b0, err);
      runProgram();
      compareOutputs();
      checkFlag("err after second run", 1'b0, err);
      endTest();
   endtask

   initial
   begin
      void'($urandom(32'h1613));
      clk      = 1'b0;
      rst      = 1'b1;
      loadEn   = 1'b0;
      loadAddr = '0;
      loadData = '0;
      start    = 1'b0;
      repeat (4) @(posedge clk);
      rst <= 1'b0;
      testIdle();
      testArith();
      testMemory();
      testControl();
      testErrors();
      testRestart();
      $display("Tests: %0d, checks: %0d, errors: %0d", testCount, checkCount, errorCount);
      if (errorCount == 0)
      begin
         $display("SIMULATION PASSED");
      end
      else
      begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- flist.f
hw/cpuPkg.sv
hw/instrFetch.sv
hw/controlUnit.sv
hw/registerFile.sv
hw/executeUnit.sv
hw/memoryAccess.sv
hw/cpuTop.sv
verification/cpuTop_properties.sv
verification/cpuTb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --assert -j 0
TOP       = cpuTb
FLIST     = flist.f
OBJDIR    = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FLIST)
	out=$$(./$(OBJDIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf $(OBJDIR)
